// ==== common/fetch_pkg.sv ====
package fetch_pkg;

  localparam int xlen = 32;

  // RV32 major opcodes, instruction bits 6 to 2
  typedef enum logic [4:0] {
    op_branch = 5'b11000,
    op_jal    = 5'b11011,
    op_other  = 5'b00000
  } opcode_t;

  typedef enum logic {
    st_wait = 1'b0, // Waiting for a cache hit
    st_hold = 1'b1  // Fetched instruction parked behind a stalled output
  } fetch_state_t;

  typedef enum logic [1:0] {
    c_idle = 2'd0,
    c_addr = 2'd1, // Address presented
    c_data = 2'd2  // Waiting for data
  } cache_state_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] addr;
  } mem_ar_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] data;
  } mem_r_t;

  // Jump and control-status flushes share this shape
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
  } fetch_out_t;

endpackage

// ==== fetch/fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit
  import fetch_pkg::*;
#(
  parameter logic [xlen-1:0] reset_pc = 32'h8000_0000,
  parameter int cache_lines = 16
) (
  input  logic         clock,
  input  logic         reset,
  input  redirect_t    jump,
  input  redirect_t    cs,
  input  logic         fencei,
  input  logic         out_ready,
  output logic         out_valid,
  output fetch_out_t   out,
  output mem_ar_t      mem_ar,
  input  logic         mem_ar_ready,
  input  mem_r_t       mem_r,
  output logic         mem_r_ready,
  output fetch_state_t state
);

  logic            hit;
  logic [xlen-1:0] cache_inst;
  logic [xlen-1:0] fetch_pc;
  logic [xlen-1:0] fetch_pc_next;

  fetch_state_t state_next;
  logic         out_valid_r;
  logic         out_valid_r_next;
  fetch_out_t   out_next;

  logic            flush;
  logic [xlen-1:0] target;
  logic            flush_pend;        // Flush seen during a miss
  logic            flush_pend_next;
  logic [xlen-1:0] flush_target;
  logic [xlen-1:0] flush_target_next;

  logic [4:0]      opcode;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] pc_incr;
  logic [xlen-1:0] fetch_pc_pred;

  icache #(
    .cache_lines(cache_lines)
  ) icache_i (
    .clock       (clock),
    .reset       (reset),
    .fencei      (fencei),
    .addr        (fetch_pc),
    .hit         (hit),
    .inst        (cache_inst),
    .mem_ar      (mem_ar),
    .mem_ar_ready(mem_ar_ready),
    .mem_r       (mem_r),
    .mem_r_ready (mem_r_ready)
  );

  assign flush = jump.valid | cs.valid;
  assign target = cs.valid ? cs.target : jump.target; // cs wins

  // Static prediction: backward branches taken, everything else falls through
  assign opcode = cache_inst[6:2];
  assign imm_b = {{20{cache_inst[31]}}, cache_inst[7], cache_inst[30:25],
                  cache_inst[11:8], 1'b0};
  assign pc_incr = (opcode == op_branch && cache_inst[31]) ? imm_b : 32'd4;
  assign fetch_pc_pred = fetch_pc + pc_incr;

  always_comb begin
    state_next = state;
    out_valid_r_next = out_valid_r;
    out_next = out;
    fetch_pc_next = fetch_pc;
    flush_pend_next = flush_pend;
    flush_target_next = flush_target;

    case (state)
      st_wait: begin
        if (hit) begin
          if (flush || flush_pend) begin
            flush_pend_next = 1'b0; // Stale instruction dropped
            out_valid_r_next = 1'b0;
            fetch_pc_next = flush ? target : flush_target;
          end else if (!out_valid_r || out_ready) begin
            out_valid_r_next = 1'b1;
            out_next = '{pc: fetch_pc, inst: cache_inst};
            fetch_pc_next = fetch_pc_pred;
          end else begin
            state_next = st_hold;
          end
        end else begin
          if (flush) begin
            flush_pend_next = 1'b1;
            flush_target_next = target;
          end
          if (out_ready || flush) begin
            out_valid_r_next = 1'b0;
          end
        end
      end
      st_hold: begin
        if (flush) begin
          state_next = st_wait;
          out_valid_r_next = 1'b0;
          fetch_pc_next = target;
        end else if (out_ready) begin
          state_next = st_wait;
          out_valid_r_next = hit;
          if (hit) begin
            out_next = '{pc: fetch_pc, inst: cache_inst};
            fetch_pc_next = fetch_pc_pred;
          end
        end
      end
      default: state_next = st_wait;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_wait;
      out_valid_r <= 1'b0;
      flush_pend <= 1'b0;
      fetch_pc <= reset_pc;
    end else begin
      state <= state_next;
      out_valid_r <= out_valid_r_next;
      flush_pend <= flush_pend_next;
      fetch_pc <= fetch_pc_next;
    end
  end

  always_ff @(posedge clock) begin
    out <= out_next;
    flush_target <= flush_target_next;
  end

  assign out_valid = out_valid_r & ~flush; // Never deliver in a flush cycle

endmodule

// ==== fetch/icache.sv ====
`timescale 1ns/100ps

module icache
  import fetch_pkg::*;
#(
  parameter int cache_lines = 16
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            fencei,
  input  logic [xlen-1:0] addr,
  output logic            hit,
  output logic [xlen-1:0] inst,
  output mem_ar_t         mem_ar,
  input  logic            mem_ar_ready,
  input  mem_r_t          mem_r,
  output logic            mem_r_ready
);

  localparam int index_bits = $clog2(cache_lines);
  localparam int tag_bits = xlen - index_bits - 2;

  logic [cache_lines-1:0] valid_bits;
  logic [tag_bits-1:0]    tags [cache_lines];
  logic [xlen-1:0]        lines [cache_lines];

  cache_state_t    state;
  logic [xlen-1:0] miss_addr; // Address of the refill in flight
  logic            dropped;   // Refill overtaken by a fence.i

  logic [index_bits-1:0] index;
  logic [index_bits-1:0] fill_index;
  logic [tag_bits-1:0]   tag;
  logic [tag_bits-1:0]   fill_tag;
  logic                  miss_start;
  logic                  fill;

  // Word addressed, so bits 1 to 0 never take part
  assign index = addr[index_bits+1:2];
  assign tag = addr[xlen-1:index_bits+2];
  assign fill_index = miss_addr[index_bits+1:2];
  assign fill_tag = miss_addr[xlen-1:index_bits+2];

  assign hit = valid_bits[index] && (tags[index] == tag);
  assign inst = lines[index];

  assign miss_start = (state == c_idle) && !hit;

  // Line is written on the data transfer, unless fence.i has voided it
  assign fill = (state == c_data) && mem_r.valid && !dropped && !fencei;

  assign mem_ar = '{valid: (state == c_addr), addr: miss_addr};
  assign mem_r_ready = (state == c_data);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= c_idle;
      valid_bits <= '0;
      dropped <= 1'b0;
    end else begin
      case (state)
        c_idle: begin
          if (!hit) begin
            state <= c_addr;
            dropped <= 1'b0;
          end
        end
        c_addr: begin
          if (mem_ar_ready) begin
            state <= c_data;
          end
        end
        c_data: begin
          if (mem_r.valid) begin
            state <= c_idle;
          end
        end
        default: state <= c_idle;
      endcase

      if (fill) begin
        valid_bits[fill_index] <= 1'b1;
      end

      if (fencei) begin
        valid_bits <= '0;
        if (state != c_idle) begin
          dropped <= 1'b1; // Let the channel finish, discard the word
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (miss_start) begin
      miss_addr <= addr;
    end
    if (fill) begin
      tags[fill_index] <= fill_tag;
      lines[fill_index] <= mem_r.data;
    end
  end

endmodule

// ==== list.f ====
common/fetch_pkg.sv
fetch/icache.sv
fetch/fetch_unit.sv
source/fetch_perf.sv
source/fetch_top.sv
testbench/fetch_mem_model.sv
testbench/fetch_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the fetch testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary -Wno-fatal -f list.f --top-module fetch_tb -o fetch_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Compile failed with status $status"
  exit 1
fi

./obj_dir/fetch_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "All checks passed" "$log"; then
  echo "PASS"
  exit 0
fi

echo "FAIL"
exit 1

// ==== source/fetch_perf.sv ====
`timescale 1ns/100ps

module fetch_perf
  import fetch_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  fetch_state_t state,
  input  logic         out_valid,
  input  logic         out_ready,
  output logic [31:0]  hold_count,
  output logic [31:0]  wait_count,
  output logic [31:0]  inst_count
);

  localparam int counter_width = 32;

  logic [counter_width-1:0] hold_r;
  logic [counter_width-1:0] wait_r;
  logic [counter_width-1:0] inst_r;

  // Stops at all ones instead of wrapping
  function automatic logic [counter_width-1:0] sat_inc(
    input logic [counter_width-1:0] value,
    input logic                     event_seen
  );
    if (event_seen && value != '1) begin
      return value + 1'b1;
    end
    return value;
  endfunction

  always_ff @(posedge clock) begin
    if (reset) begin
      hold_r <= '0;
      wait_r <= '0;
      inst_r <= '0;
    end else begin
      hold_r <= sat_inc(hold_r, state == st_hold);
      wait_r <= sat_inc(wait_r, state == st_wait);
      inst_r <= sat_inc(inst_r, out_valid && out_ready);
    end
  end

  assign hold_count = hold_r;
  assign wait_count = wait_r;
  assign inst_count = inst_r;

endmodule

// ==== source/fetch_top.sv ====
`timescale 1ns/100ps

module fetch_top
  import fetch_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  redirect_t   jump,
  input  redirect_t   cs,
  input  logic        fencei,
  input  logic        out_ready,
  output logic        out_valid,
  output fetch_out_t  out,
  output mem_ar_t     mem_ar,
  input  logic        mem_ar_ready,
  input  mem_r_t      mem_r,
  output logic        mem_r_ready,
  output logic [31:0] hold_count,
  output logic [31:0] wait_count,
  output logic [31:0] inst_count
);

  fetch_state_t state;

  fetch_unit #(
    .reset_pc   (32'h8000_0000),
    .cache_lines(16)
  ) fetch_unit_i (
    .clock       (clock),
    .reset       (reset),
    .jump        (jump),
    .cs          (cs),
    .fencei      (fencei),
    .out_ready   (out_ready),
    .out_valid   (out_valid),
    .out         (out),
    .mem_ar      (mem_ar),
    .mem_ar_ready(mem_ar_ready),
    .mem_r       (mem_r),
    .mem_r_ready (mem_r_ready),
    .state       (state)
  );

  fetch_perf fetch_perf_i (
    .clock     (clock),
    .reset     (reset),
    .state     (state),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .hold_count(hold_count),
    .wait_count(wait_count),
    .inst_count(inst_count)
  );

endmodule

// ==== testbench/fetch_mem_model.sv ====
`timescale 1ns/100ps

module fetch_mem_model
  import fetch_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  mem_ar_t mem_ar,
  output logic    mem_ar_ready,
  output mem_r_t  mem_r,
  input  logic    mem_r_ready
);

  // Word array, loaded and updated by the testbench, indexed by address bits 11 to 2
  logic [xlen-1:0] mem [1024];

  logic [xlen-1:0] read_addr;
  logic [xlen-1:0] ar_addr;
  logic            pending;   // Address accepted, data not yet returned
  logic            ar_fire;
  logic            r_fire;
  int              ar_delay;
  int              r_delay;

  initial begin
    mem_ar_ready = 1'b0;
    mem_r = '0;
    pending = 1'b0;
    read_addr = '0;
    ar_delay = 0;
    r_delay = 0;
    forever begin
      @(posedge clock);
      ar_fire = mem_ar.valid && mem_ar_ready; // Transfers seen at the edge
      ar_addr = mem_ar.addr;
      r_fire = mem_r.valid && mem_r_ready;
      #10;
      if (reset) begin
        mem_ar_ready = 1'b0;
        mem_r = '0;
        pending = 1'b0;
        ar_delay = $urandom % 6;
      end else begin
        if (r_fire) begin
          mem_r = '0;
        end
        if (ar_fire) begin
          mem_ar_ready = 1'b0;
          pending = 1'b1;
          read_addr = ar_addr;
          ar_delay = $urandom % 6;
          r_delay = $urandom % 6;
        end else if (!mem_ar_ready) begin
          if (ar_delay == 0) begin
            mem_ar_ready = 1'b1;
          end else begin
            ar_delay = ar_delay - 1;
          end
        end
        if (pending && !mem_r.valid) begin
          if (r_delay == 0) begin
            mem_r = '{valid: 1'b1, data: mem[read_addr[11:2]]};
            pending = 1'b0;
          end else begin
            r_delay = r_delay - 1;
          end
        end
      end
    end
  end

endmodule

// ==== testbench/fetch_tb.sv ====
`timescale 1ns/100ps

module fetch_tb
  import fetch_pkg::*;
;

  localparam int run_cycles = 20000;
  localparam int limit_cycles = 25000;
  localparam int fence_period = 2500;
  localparam logic [31:0] reset_pc = 32'h8000_0000;

  logic        clock;
  logic        reset;
  redirect_t   jump;
  redirect_t   cs;
  logic        fencei;
  logic        out_ready;
  logic        out_valid;
  fetch_out_t  out;
  mem_ar_t     mem_ar;
  logic        mem_ar_ready;
  mem_r_t      mem_r;
  logic        mem_r_ready;
  logic [31:0] hold_count;
  logic [31:0] wait_count;
  logic [31:0] inst_count;

  logic [31:0] prog [1024]; // Reference copy of the memory
  logic [31:0] expected_pc;
  logic [31:0] last_pc;     // Most recently delivered PC, likely still cached
  logic [31:0] fence_pc;
  logic        fence_wait;  // New word written, not yet delivered
  logic        prev_stall;
  fetch_out_t  prev_out;
  int          mismatches;
  int          failures;
  int          xfers;
  int          stall_cycles;
  int          idle_cycles; // No output and no flush, so the unit must be waiting
  int          edges;
  int          fence_count;
  int          pick;

  fetch_top fetch_top_i (
    .clock(clock), .reset(reset), .jump(jump), .cs(cs), .fencei(fencei),
    .out_ready(out_ready), .out_valid(out_valid), .out(out),
    .mem_ar(mem_ar), .mem_ar_ready(mem_ar_ready), .mem_r(mem_r),
    .mem_r_ready(mem_r_ready), .hold_count(hold_count),
    .wait_count(wait_count), .inst_count(inst_count)
  );

  fetch_mem_model fetch_mem_model_i (
    .clock(clock), .reset(reset), .mem_ar(mem_ar), .mem_ar_ready(mem_ar_ready),
    .mem_r(mem_r), .mem_r_ready(mem_r_ready)
  );

  // Conditional branch with a short word-aligned offset of either sign
  function automatic logic [31:0] random_branch();
    logic [12:0] off;
    logic [31:0] w;
    off = 13'((($urandom % 16) + 1) * 4);
    if ($urandom % 2 == 1) begin
      off = -off;
    end
    w = $urandom;
    w[31] = off[12];
    w[30:25] = off[10:5];
    w[11:8] = off[4:1];
    w[7] = off[11];
    w[6:0] = 7'b1100011;
    return w;
  endfunction

  function automatic logic [31:0] random_other();
    logic [31:0] w;
    w = $urandom;
    if (w[6:2] == op_branch) begin
      w[2] = ~w[2];
    end
    return w;
  endfunction

  function automatic logic [31:0] random_target();
    return {20'h80000, 10'($urandom % 1024), 2'b00};
  endfunction

  // Backward branches taken, all else falls through
  function automatic logic [31:0] next_pc(input logic [31:0] pc, input logic [31:0] inst);
    logic [31:0] imm;
    imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    if (inst[6:2] == op_branch && inst[31]) begin
      return pc + imm;
    end
    return pc + 32'd4;
  endfunction

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    prog[addr[11:2]] = data;
    fetch_mem_model_i.mem[addr[11:2]] = data;
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    mismatches++;
    $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, expected, actual);
  endtask

  task automatic report_failure(input string what);
    failures++;
    $display("ERROR time=%0t %s", $time, what);
  endtask

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  initial begin
    #(limit_cycles * 100);
    $display("ERROR time=%0t run did not finish within %0d cycles", $time, limit_cycles);
    $display("Checks failed");
    $finish;
  end

  always @(posedge clock) begin
    if (!reset) begin
      edges++;
    end
  end

  // Sampled mid-cycle, where inputs and outputs are both settled
  always @(negedge clock) begin
    if (!reset) begin
      if (inst_count != 32'(xfers)) report_mismatch("inst_count", 32'(xfers), inst_count);
      if (hold_count + wait_count != 32'(edges)) begin
        report_mismatch("hold_count+wait_count", 32'(edges), hold_count + wait_count);
      end
      if (wait_count < 32'(idle_cycles)) begin
        report_failure($sformatf("wait_count %0d is below the %0d cycles with nothing to offer",
                                 wait_count, idle_cycles));
      end
      if (prev_stall) begin
        if (!out_valid && !jump.valid && !cs.valid) begin
          report_failure("out_valid dropped before the transfer");
        end else if (out_valid && out.pc != prev_out.pc) begin
          report_mismatch("out.pc (stalled)", prev_out.pc, out.pc);
        end else if (out_valid && out.inst != prev_out.inst) begin
          report_mismatch("out.inst (stalled)", prev_out.inst, out.inst);
        end
      end
      if (jump.valid || cs.valid) begin
        if (out_valid) report_failure("out_valid high in a flush cycle");
        expected_pc = cs.valid ? cs.target : jump.target;
      end else if (out_valid && out_ready) begin
        if (out.pc != expected_pc) report_mismatch("out.pc", expected_pc, out.pc);
        if (out.inst != prog[expected_pc[11:2]]) begin
          report_mismatch("out.inst", prog[expected_pc[11:2]], out.inst);
        end
        if (fence_wait && out.pc == fence_pc) fence_wait = 1'b0;
        xfers++;
        last_pc = out.pc;
        expected_pc = next_pc(expected_pc, prog[expected_pc[11:2]]);
      end
      if (!out_valid && !jump.valid && !cs.valid) idle_cycles++;
      if (out_valid && !out_ready) stall_cycles++;
      prev_stall = out_valid && !out_ready;
      prev_out = out;
    end
  end

  initial begin
    void'($urandom(32'h474e_8863));
    reset = 1'b1;
    jump = '0;
    cs = '0;
    fencei = 1'b0;
    out_ready = 1'b0;
    expected_pc = reset_pc;
    last_pc = reset_pc;
    fence_pc = '0;
    fence_wait = 1'b0;
    prev_stall = 1'b0;
    prev_out = '0;
    mismatches = 0;
    failures = 0;
    xfers = 0;
    stall_cycles = 0;
    idle_cycles = 0;
    edges = 0;
    fence_count = 0;
    for (int i = 0; i < 1024; i++) begin
      if ($urandom % 100 < 15) write_word(32'(i * 4), random_branch());
      else write_word(32'(i * 4), random_other());
    end
    repeat (3) @(posedge clock);
    #10 reset = 1'b0;
    for (int cycle = 0; cycle < run_cycles; cycle++) begin
      @(posedge clock);
      #10;
      jump = '0;
      cs = '0;
      fencei = 1'b0;
      out_ready = ($urandom % 100) < 70;
      pick = $urandom % 1000;
      if (cycle % fence_period == fence_period / 2 && !fence_wait) begin
        fence_pc = last_pc;
        write_word(fence_pc, random_other());
        cs = '{valid: 1'b1, target: fence_pc};
        fencei = 1'b1;
        fence_wait = 1'b1;
        fence_count++;
      end else if (!fence_wait) begin
        if (pick < 20) jump = '{valid: 1'b1, target: random_target()};
        if (pick >= 15 && pick < 25) cs = '{valid: 1'b1, target: random_target()}; // Overlap 15..19
      end
    end
    @(posedge clock);
    #10;
    jump = '0;
    cs = '0;
    fencei = 1'b0;
    out_ready = 1'b1;
    repeat (20) @(posedge clock);
    @(negedge clock);
    if (fence_wait) report_failure("instruction written before fence.i was never delivered");
    $display("Summary: %0d transfers, %0d stalls, %0d fence.i tests, %0d mismatches, %0d errors",
             xfers, stall_cycles, fence_count, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
